/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tpc_tb
FILELIST   = tb.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb.f */
tpc_pkg.sv
tpc_request.sv
tpc_fifo.sv
tpc_tlp_builder.sv
tpc_top.sv
tpc_chk.sv
tpc_monitor.sv
tpc_tb.sv

/* tpc_chk.sv */
/*
 * tpc transmit stream checker
 * bound into the top level, watches the handshake and reset values
 */
`timescale 1ns/1ps

module tpc_chk (
   input  logic            clock,
   input  logic            reset,
   input  logic            i_tx_valid,
   input  tpc_pkg::qword_t i_tx_data,
   input  logic            i_tx_last,
   input  logic            i_tx_ready,
   input  logic            i_req_ready,
   input  logic [31:0]     i_status
);
   int hold_fails = 0;
   int reset_fails = 0;
   int last_fails = 0;
   int fail_count;

   assign fail_count = hold_fails + reset_fails + last_fails;   // all assertion failures

   // stalled beat must not move
   tx_hold: assert property (@(posedge clock) disable iff (reset)
      (i_tx_valid && !i_tx_ready) |=>
         (i_tx_valid && $stable(i_tx_data) && $stable(i_tx_last)))
   else
   begin
      hold_fails++;
      $error("tx beat changed while i_tx_ready was low");
   end

   // first cycle out of reset
   reset_state: assert property (@(posedge clock)
      $past(reset) |-> (!i_tx_valid && i_req_ready && (i_status == 32'h0)))
   else
   begin
      reset_fails++;
      $error("outputs not at reset values after reset");
   end

   tx_last_valid: assert property (@(posedge clock) disable iff (reset)
      i_tx_last |-> i_tx_valid)
   else
   begin
      last_fails++;
      $error("o_tx_last high without o_tx_valid");
   end

endmodule

/* tpc_fifo.sv */
/*
 * tpc data buffer
 * synchronous first-word-fall-through ram fifo for producer words,
 * registered fill level for the builder's start check
 */
`timescale 1ns/1ps

module tpc_fifo #(
   parameter int FIFO_DEPTH_LOG2 = tpc_pkg::FIFO_DEPTH_LOG2_DEF
) (
   input  logic                     clock,
   input  logic                     reset,
   // producer side
   input  logic                     i_data_valid,
   input  tpc_pkg::qword_t          i_data,
   output logic                     o_data_ready,
   // builder side
   input  logic                     i_rd_en,
   output tpc_pkg::qword_t          o_rd_data,
   output logic [FIFO_DEPTH_LOG2:0] o_level
);
   import tpc_pkg::*;

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
   localparam logic [FIFO_DEPTH_LOG2:0] FULL_LEVEL = (FIFO_DEPTH_LOG2 + 1)'(DEPTH);

   qword_t                     mem [DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic                       push;
   logic                       pop;

   assign o_data_ready = o_level != FULL_LEVEL;
   assign push = i_data_valid && o_data_ready;
   assign pop = i_rd_en && (o_level != '0);   // read on empty is dropped

   // head word always visible
   assign o_rd_data = mem[rd_ptr];

   always_ff @(posedge clock)
   begin
      if (push)
         mem[wr_ptr] <= i_data;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         o_level <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // level follows push/pop one cycle later
         if (push && !pop)
            o_level <= o_level + 1'b1;
         else if (pop && !push)
            o_level <= o_level - 1'b1;
      end
   end

endmodule

/* tpc_monitor.sv */
/*
 * tpc transmit monitor
 * reference model of the write engine, rebuilds every tlp from the
 * accepted descriptors and producer words, compares beats and status
 */
`timescale 1ns/1ps

module tpc_monitor (
   input  logic             clock,
   input  logic             reset,
   input  tpc_pkg::req_id_t i_req_id,
   input  logic             i_req_valid,
   input  tpc_pkg::qaddr_t  i_req_addr,
   input  tpc_pkg::qcount_t i_req_count,
   input  logic             i_req_abort,
   input  logic             i_req_ready,
   input  logic             i_data_valid,
   input  tpc_pkg::qword_t  i_data,
   input  logic             i_data_ready,
   input  logic             i_tx_valid,
   input  tpc_pkg::qword_t  i_tx_data,
   input  logic             i_tx_last,
   input  logic             i_tx_ready,
   input  logic [31:0]      i_status,
   output int               o_data_errors,
   output int               o_last_errors,
   output int               o_status_errors,
   output int               o_other_errors,
   output int               o_pending,   // chunks not fully sent yet
   output int               o_tlps
);
   import tpc_pkg::*;

   qword_t word_q [$];     // producer words, in order
   qaddr_t chunk_q [$];    // chunk addresses still owed
   qaddr_t cur_addr;
   qword_t cur_words [16];
   logic   busy;           // tlp on the wire
   int     beat;           // index of next beat to arrive
   int     words_sent;

   // pcie payload byte order, lane by lane
   function automatic logic [31:0] swap_bytes(input logic [31:0] x);
      logic [31:0] r;
      int i;
      for (i = 0; i < 4; i++)
         r[8*i +: 8] = x[8*(3-i) +: 8];
      return r;
   endfunction

   // whole tlp as a dword stream, two dwords per beat
   function automatic qword_t expected_beat(input int b);
      logic [63:0] byte_addr;
      logic [31:0] s [36];
      logic [2:0]  fmt;
      int          n;
      int          k;
      byte_addr = {cur_addr, 3'b000};
      fmt = (byte_addr[63:32] == 32'h0) ? 3'b010 : 3'b011;   // 3dw or 4dw write
      s[0] = {fmt, 5'b00000, 14'h0, 10'd32};   // mwr, 32 dwords
      s[1] = {i_req_id, 8'h00, 8'hff};         // tag 0, all bytes enabled
      if (fmt == 3'b010)
      begin
         s[2] = byte_addr[31:0];
         n = 3;
      end
      else
      begin
         s[2] = byte_addr[63:32];
         s[3] = byte_addr[31:0];
         n = 4;
      end
      for (k = 0; k < 16; k++)
      begin
         s[n + 2*k] = swap_bytes(cur_words[k][31:0]);
         s[n + 2*k + 1] = swap_bytes(cur_words[k][63:32]);
      end
      if (n == 3)
         s[35] = 32'h0;   // pad after last dword
      return {s[2*b + 1], s[2*b]};
   endfunction

   task automatic claim_chunk();
      int k;
      cur_addr = '0;
      if (chunk_q.size() == 0)
      begin
         o_other_errors++;
         $display("tlp started while no chunk was queued");
      end
      else
         cur_addr = chunk_q.pop_front();
      if (word_q.size() < 16)
      begin
         o_other_errors++;
         $display("tlp started with fewer than 16 producer words accepted");
      end
      else
      begin
         for (k = 0; k < 16; k++)
            cur_words[k] = word_q.pop_front();
      end
      busy = 1'b1;
      beat = 0;
   endtask

   task automatic check_beat();
      qword_t exp;
      logic   exp_last;
      exp = expected_beat(beat);
      exp_last = beat == 17;   // 18th beat only
      if (i_tx_data !== exp)
      begin
         o_data_errors++;
         $display("error o_tx_data exp %h got %h (tlp %0d beat %0d)",
                  exp, i_tx_data, o_tlps, beat);
      end
      if (i_tx_last !== exp_last)
      begin
         o_last_errors++;
         $display("error o_tx_last exp %h got %h (tlp %0d beat %0d)",
                  exp_last, i_tx_last, o_tlps, beat);
      end
      if (beat >= 2)
         words_sent++;   // payload beats
      if (beat == 17)
      begin
         busy = 1'b0;
         o_tlps++;
      end
      else
         beat++;
   endtask

   always @(posedge clock)
   begin
      qcount_t k;
      if (reset)
      begin
         word_q.delete();
         chunk_q.delete();
         busy = 1'b0;
         beat = 0;
         words_sent = 0;
         o_data_errors = 0;
         o_last_errors = 0;
         o_status_errors = 0;
         o_other_errors = 0;
         o_tlps = 0;
      end
      else
      begin
         if (i_data_valid && i_data_ready)
            word_q.push_back(i_data);
         if (i_req_valid && i_req_ready)
         begin
            for (k = 0; k < i_req_count; k = k + 32'd16)
               chunk_q.push_back(i_req_addr + qaddr_t'(k));   // 128 bytes apart
         end
         if (i_tx_valid && !busy)
            claim_chunk();
         if (i_req_abort)
            chunk_q.delete();   // tlp in flight is already claimed
         if (i_status !== 32'(words_sent * 8))
         begin
            o_status_errors++;
            $display("error o_status exp %h got %h", 32'(words_sent * 8), i_status);
         end
         if (i_tx_valid && i_tx_ready)
            check_beat();
      end
      o_pending = chunk_q.size() + (busy ? 1 : 0);
   end

endmodule

/* tpc_pkg.sv */
/*
 * tpc shared definitions
 * widths for addresses, lengths and beats, memory-write header words
 * and the dword byte swap used on every data dword
 */
package tpc_pkg;

   localparam int FIFO_DEPTH_LOG2_DEF = 6;   // 64 word buffer by default
   localparam int CHUNK_WORDS = 16;          // 128 bytes per tlp
   localparam int TLP_BEATS = 18;            // header beats plus data

   typedef logic [60:0] qaddr_t;    // host address, 8 byte units
   typedef logic [31:0] qcount_t;   // length, 8 byte words
   typedef logic [63:0] qword_t;    // producer word / tx beat
   typedef logic [15:0] req_id_t;   // bus/dev/fn
   typedef logic [FIFO_DEPTH_LOG2_DEF:0] level_t;  // one extra bit for full

   // dword0 holds fmt in [31:29], type 0 and length 32 dwords
   localparam logic [31:0] HDR_MWR32 = 32'h4000_0020;  // fmt 2, 3dw
   localparam logic [31:0] HDR_MWR64 = 32'h6000_0020;  // fmt 3, 4dw

   // last be in [7:4], first be in [3:0]
   localparam logic [7:0] BE_FULL = 8'hff;

   // pcie payload is little endian per dword
   function automatic logic [31:0] endian_swap(input logic [31:0] x);
      return {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

endpackage

/* tpc_request.sv */
/*
 * tpc request stage
 * small circular descriptor queue, the head descriptor is cut into
 * 16 word chunks which are offered to the tlp builder
 */
`timescale 1ns/1ps

module tpc_request #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic             clock,
   input  logic             reset,
   // descriptors in
   input  logic             i_req_valid,
   input  tpc_pkg::qaddr_t  i_req_addr,    // 8 byte units
   input  tpc_pkg::qcount_t i_req_count,   // 8 byte words, multiple of 16
   input  logic             i_req_abort,
   output logic             o_req_ready,
   // chunks out
   output logic             o_chunk_valid,
   output tpc_pkg::qaddr_t  o_chunk_addr,
   input  logic             i_chunk_ready
);
   import tpc_pkg::*;

   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam logic [PTR_W:0] FULL_LEVEL = (PTR_W + 1)'(QUEUE_DEPTH);

   qaddr_t           q_addr  [QUEUE_DEPTH];
   qcount_t          q_count [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   used;         // entries held
   qcount_t          done_words;   // words already chunked from the head
   qcount_t          head_left;
   logic             push;
   logic             pop;
   logic             chunk_take;
   logic             head_done;

   // abort blocks both sides for the cycle it clears the queue
   assign o_req_ready = (used != FULL_LEVEL) && !i_req_abort;
   assign push = i_req_valid && o_req_ready;

   assign head_left = q_count[rd_ptr] - done_words;
   assign head_done = head_left <= qcount_t'(CHUNK_WORDS);  // last chunk of descriptor

   assign o_chunk_valid = (used != '0) && !i_req_abort;
   assign o_chunk_addr = q_addr[rd_ptr] + qaddr_t'(done_words);
   assign chunk_take = o_chunk_valid && i_chunk_ready;
   assign pop = chunk_take && head_done;   // retire head

   // descriptor storage
   always_ff @(posedge clock)
   begin
      if (push)
      begin
         q_addr[wr_ptr] <= i_req_addr;
         q_count[wr_ptr] <= i_req_count;
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset || i_req_abort)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used <= '0;
         done_words <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;   // depth is a power of 2, wraps
         if (pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
            done_words <= '0;
         end
         else if (chunk_take)
            done_words <= done_words + qcount_t'(CHUNK_WORDS);  // walk up 128 bytes
         if (push && !pop)
            used <= used + 1'b1;
         else if (pop && !push)
            used <= used - 1'b1;
      end
   end

endmodule

/* tpc_tb.sv */
/*
 * tpc write engine testbench
 * seeded random descriptors, producer words and tx back-pressure,
 * one abort mid-run, monitor does the comparing
 */
`timescale 1ns/1ps

module tpc_tb;
   import tpc_pkg::*;

   localparam int NUM_DESC = 12;
   localparam int ABORT_AFTER = 6;   // abort once this descriptor is in

   logic        clock;
   logic        reset;
   req_id_t     req_id;
   logic        req_valid;
   qaddr_t      req_addr;
   qcount_t     req_count;
   logic        req_abort;
   logic        req_ready;
   logic        data_valid;
   qword_t      data_word;
   logic        data_ready;
   logic        tx_valid;
   qword_t      tx_data;
   logic        tx_last;
   logic        tx_ready;
   logic [31:0] status;

   int          data_errors;
   int          last_errors;
   int          status_errors;
   int          other_errors;
   int          pending;
   int          tlps;
   int          cycle_count = 0;
   int          cycle_limit = 1000000;   // replaced once descriptors exist
   qaddr_t      desc_addr [NUM_DESC];
   qcount_t     desc_count [NUM_DESC];

   tpc_top #(
      .FIFO_DEPTH_LOG2(6),
      .QUEUE_DEPTH(4)
   ) tpc_top_i (
      .clock        (clock),
      .reset        (reset),
      .i_req_id     (req_id),
      .o_status     (status),
      .i_req_valid  (req_valid),
      .i_req_addr   (req_addr),
      .i_req_count  (req_count),
      .i_req_abort  (req_abort),
      .o_req_ready  (req_ready),
      .i_data_valid (data_valid),
      .i_data       (data_word),
      .o_data_ready (data_ready),
      .o_tx_valid   (tx_valid),
      .o_tx_data    (tx_data),
      .o_tx_last    (tx_last),
      .i_tx_ready   (tx_ready)
   );

   tpc_monitor tpc_monitor_i (
      .clock           (clock),
      .reset           (reset),
      .i_req_id        (req_id),
      .i_req_valid     (req_valid),
      .i_req_addr      (req_addr),
      .i_req_count     (req_count),
      .i_req_abort     (req_abort),
      .i_req_ready     (req_ready),
      .i_data_valid    (data_valid),
      .i_data          (data_word),
      .i_data_ready    (data_ready),
      .i_tx_valid      (tx_valid),
      .i_tx_data       (tx_data),
      .i_tx_last       (tx_last),
      .i_tx_ready      (tx_ready),
      .i_status        (status),
      .o_data_errors   (data_errors),
      .o_last_errors   (last_errors),
      .o_status_errors (status_errors),
      .o_other_errors  (other_errors),
      .o_pending       (pending),
      .o_tlps          (tlps)
   );

   bind tpc_top tpc_chk tpc_chk_i (
      .clock       (clock),
      .reset       (reset),
      .i_tx_valid  (o_tx_valid),
      .i_tx_data   (o_tx_data),
      .i_tx_last   (o_tx_last),
      .i_tx_ready  (i_tx_ready),
      .i_req_ready (o_req_ready),
      .i_status    (o_status)
   );

   initial
   begin
      clock = 1'b0;
      forever
         #2 clock = ~clock;   // 4 ns period
   end

   // run limit
   always @(posedge clock)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("timeout after %0d cycles, transmit stream never drained", cycle_count);
         $display("sim failed");
         $finish;
      end
   end

   // hold the descriptor until the request stage takes it
   task automatic send_desc(input qaddr_t addr, input qcount_t count);
      logic accepted;
      @(posedge clock);
      req_valid <= 1'b1;
      req_addr <= addr;
      req_count <= count;
      accepted = 1'b0;
      while (!accepted)
      begin
         @(negedge clock);
         accepted = req_ready;
         @(posedge clock);
      end
      req_valid <= 1'b0;
   endtask

   // one-cycle abort while a tlp is on the wire
   task automatic pulse_abort();
      @(negedge clock);
      while (!tx_valid)
         @(negedge clock);
      repeat (1 + $urandom % 4) @(negedge clock);
      @(posedge clock);
      req_abort <= 1'b1;
      @(posedge clock);
      req_abort <= 1'b0;
   endtask

   task automatic drive_producer();
      qword_t next_word;
      logic   taken;
      next_word = {$urandom, $urandom};   // counts up from here
      forever
      begin
         @(negedge clock);
         taken = data_valid && data_ready;
         @(posedge clock);
         if (taken)
            next_word = next_word + 64'd1;
         data_valid <= ($urandom % 4) != 0;   // gap about 1 in 4
         data_word <= next_word;
      end
   endtask

   task automatic drive_tx_ready();
      forever
      begin
         @(posedge clock);
         tx_ready <= ($urandom % 3) != 0;
      end
   endtask

   initial
   begin
      int          i;
      int          beats;
      int          total;
      logic        use_low;
      logic [28:0] hi;
      void'($urandom(32'he9477404));
      reset = 1'b1;
      req_valid = 1'b0;
      req_addr = '0;
      req_count = '0;
      req_abort = 1'b0;
      data_valid = 1'b0;
      data_word = '0;
      tx_ready = 1'b0;
      req_id = req_id_t'($urandom);
      beats = 0;
      for (i = 0; i < NUM_DESC; i++)
      begin
         desc_count[i] = qcount_t'(16 * (1 + $urandom % 4));   // 16..64 words
         use_low = (i == 0) || (i != 1 && ($urandom % 2) == 0);
         if (use_low)
            desc_addr[i] = qaddr_t'($urandom & 32'h1fff_fff0);   // below 4 GB
         else
         begin
            hi = 29'($urandom);
            if (hi == '0)
               hi = 29'd1;
            desc_addr[i] = {hi, $urandom & 32'hffff_fff0};
         end
         beats = beats + int'(desc_count[i] / 16) * 18;
      end
      cycle_limit = 4 * beats + 2000;
      repeat (8) @(posedge clock);
      reset <= 1'b0;
      fork
         drive_producer();
         drive_tx_ready();
      join_none
      for (i = 0; i < NUM_DESC; i++)
      begin
         repeat ($urandom % 6) @(posedge clock);
         send_desc(desc_addr[i], desc_count[i]);
         if (i == ABORT_AFTER)
            pulse_abort();
      end
      @(negedge clock);
      while (pending != 0)
         @(negedge clock);
      repeat (4) @(negedge clock);   // last status update
      total = data_errors + last_errors + status_errors + other_errors
            + tpc_top_i.tpc_chk_i.fail_count;
      $display("checks done: %0d tlps, data %0d, last %0d, status %0d, other %0d, assert %0d",
               tlps, data_errors, last_errors, status_errors, other_errors,
               tpc_top_i.tpc_chk_i.fail_count);
      if (total == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

/* tpc_tlp_builder.sv */
/*
 * tpc memory-write tlp builder
 * one 18 beat posted write per 16 word chunk, 3dw or 4dw header
 * by address, byte swapped payload packed across the header seam
 */
`timescale 1ns/1ps

module tpc_tlp_builder #(
   parameter int FIFO_DEPTH_LOG2 = tpc_pkg::FIFO_DEPTH_LOG2_DEF
) (
   input  logic                     clock,
   input  logic                     reset,
   input  tpc_pkg::req_id_t         i_req_id,
   // chunk from request stage
   input  logic                     i_chunk_valid,
   input  tpc_pkg::qaddr_t          i_chunk_addr,
   output logic                     o_chunk_ready,
   // buffer
   input  logic [FIFO_DEPTH_LOG2:0] i_level,
   input  tpc_pkg::qword_t          i_rd_data,
   output logic                     o_rd_en,
   // tx stream
   output logic                     o_tx_valid,
   output tpc_pkg::qword_t          o_tx_data,
   output logic                     o_tx_last,
   input  logic                     i_tx_ready,
   // status
   output logic                     o_word_sent
);
   import tpc_pkg::*;

   // state names the beat currently on the output
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_HEADER,    // beat 0
      ST_ADDRESS,   // beat 1
      ST_DATA       // beats 2..17
   } state_t;

   localparam level_t START_LEVEL = level_t'(CHUNK_WORDS);  // whole chunk buffered
   localparam logic [4:0] LAST_BEAT = 5'(TLP_BEATS - 1);

   state_t      state;
   logic [4:0]  beat_cnt;      // index of beat on o_tx_data
   logic        is_32;         // latched at start
   qaddr_t      addr_q;
   logic [31:0] held;          // spare swapped dword, 3dw packing
   logic        start;
   logic        advance;       // output beat taken this cycle
   logic        chunk_is_32;
   logic [31:0] addr_lo;       // byte address dwords
   logic [31:0] addr_hi;
   logic [31:0] rd_lo_sw;
   logic [31:0] rd_hi_sw;
   qword_t      next_beat;

   assign o_chunk_ready = (state == ST_IDLE) && (i_level >= START_LEVEL);
   assign start = o_chunk_ready && i_chunk_valid;
   assign advance = o_tx_valid && i_tx_ready;

   assign chunk_is_32 = i_chunk_addr[60:29] == '0;   // byte address < 4 GB
   assign addr_lo = {addr_q[28:0], 3'b000};
   assign addr_hi = addr_q[60:29];
   assign rd_lo_sw = endian_swap(i_rd_data[31:0]);
   assign rd_hi_sw = endian_swap(i_rd_data[63:32]);

   // one data word per beat from beat 2 on, either format
   assign o_word_sent = advance && (state == ST_DATA);

   // pop only when the beat being loaded eats a new word, 16 per tlp
   always_comb
   begin
      o_rd_en = 1'b0;
      if (advance)
      begin
         case (state)
            ST_HEADER:  o_rd_en = is_32;   // word 0 shares the address beat in 3dw
            ST_ADDRESS: o_rd_en = 1'b1;
            ST_DATA:
            begin
               if (beat_cnt == LAST_BEAT)
                  o_rd_en = 1'b0;
               else if (is_32 && (beat_cnt == LAST_BEAT - 5'd1))
                  o_rd_en = 1'b0;   // beat 17 only drains held
               else
                  o_rd_en = 1'b1;
            end
            default:    o_rd_en = 1'b0;
         endcase
      end
   end

   // beat that follows the one on the output
   always_comb
   begin
      next_beat = {rd_hi_sw, rd_lo_sw};   // 4dw data, one word per beat
      if (state == ST_HEADER)
      begin
         if (is_32)
            next_beat = {rd_lo_sw, addr_lo};
         else
            next_beat = {addr_lo, addr_hi};   // address high dword first
      end
      else if (is_32)
      begin
         if (beat_cnt == LAST_BEAT - 5'd1)
            next_beat = {32'h0, held};   // last dword, zero pad
         else
            next_beat = {rd_lo_sw, held};   // shifted by one dword
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         beat_cnt <= '0;
         o_tx_valid <= 1'b0;
         o_tx_last <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (start)
               begin
                  state <= ST_HEADER;
                  beat_cnt <= '0;
                  o_tx_valid <= 1'b1;
               end
            end
            ST_HEADER:
            begin
               if (advance)
               begin
                  state <= ST_ADDRESS;
                  beat_cnt <= 5'd1;
               end
            end
            ST_ADDRESS:
            begin
               if (advance)
               begin
                  state <= ST_DATA;
                  beat_cnt <= 5'd2;
               end
            end
            default:
            begin
               if (advance)
               begin
                  if (beat_cnt == LAST_BEAT)
                  begin
                     state <= ST_IDLE;   // next tlp may start now
                     beat_cnt <= '0;
                     o_tx_valid <= 1'b0;
                     o_tx_last <= 1'b0;
                  end
                  else
                  begin
                     beat_cnt <= beat_cnt + 5'd1;
                     o_tx_last <= beat_cnt == LAST_BEAT - 5'd1;
                  end
               end
            end
         endcase
      end
   end

   // beat data, held while ready is low
   always_ff @(posedge clock)
   begin
      if (start)
      begin
         is_32 <= chunk_is_32;
         addr_q <= i_chunk_addr;
         // dword1 = req id, tag 0, byte enables
         o_tx_data <= {i_req_id, 8'h00, BE_FULL, chunk_is_32 ? HDR_MWR32 : HDR_MWR64};
      end
      else if (advance)
      begin
         o_tx_data <= next_beat;
         if (o_rd_en)
            held <= rd_hi_sw;   // carried to next beat's low half
      end
   end

endmodule

/* tpc_top.sv */
/*
 * tpc dma write engine top
 * request stage, data buffer and tlp builder on one clock,
 * plus the running count of payload bytes sent
 */
`timescale 1ns/1ps

module tpc_top #(
   parameter int FIFO_DEPTH_LOG2 = tpc_pkg::FIFO_DEPTH_LOG2_DEF,
   parameter int QUEUE_DEPTH = 4   // 2 or 4 descriptors
) (
   input  logic             clock,
   input  logic             reset,
   input  tpc_pkg::req_id_t i_req_id,
   output logic [31:0]      o_status,      // bytes sent
   // descriptors
   input  logic             i_req_valid,
   input  tpc_pkg::qaddr_t  i_req_addr,
   input  tpc_pkg::qcount_t i_req_count,
   input  logic             i_req_abort,
   output logic             o_req_ready,
   // producer
   input  logic             i_data_valid,
   input  tpc_pkg::qword_t  i_data,
   output logic             o_data_ready,
   // tx stream
   output logic             o_tx_valid,
   output tpc_pkg::qword_t  o_tx_data,
   output logic             o_tx_last,
   input  logic             i_tx_ready
);
   import tpc_pkg::*;

   logic                     chunk_valid;
   logic                     chunk_ready;
   qaddr_t                   chunk_addr;
   qword_t                   rd_data;
   logic [FIFO_DEPTH_LOG2:0] level;
   logic                     rd_en;
   logic                     word_sent;
   logic [31:0]              status_q;

   tpc_request #(
      .QUEUE_DEPTH(QUEUE_DEPTH)
   ) tpc_request_i (
      .clock         (clock),
      .reset         (reset),
      .i_req_valid   (i_req_valid),
      .i_req_addr    (i_req_addr),
      .i_req_count   (i_req_count),
      .i_req_abort   (i_req_abort),
      .o_req_ready   (o_req_ready),
      .o_chunk_valid (chunk_valid),
      .o_chunk_addr  (chunk_addr),
      .i_chunk_ready (chunk_ready)
   );

   tpc_fifo #(
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) tpc_fifo_i (
      .clock        (clock),
      .reset        (reset),
      .i_data_valid (i_data_valid),
      .i_data       (i_data),
      .o_data_ready (o_data_ready),
      .i_rd_en      (rd_en),
      .o_rd_data    (rd_data),
      .o_level      (level)
   );

   tpc_tlp_builder #(
      .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
   ) tpc_tlp_builder_i (
      .clock         (clock),
      .reset         (reset),
      .i_req_id      (i_req_id),
      .i_chunk_valid (chunk_valid),
      .i_chunk_addr  (chunk_addr),
      .o_chunk_ready (chunk_ready),
      .i_level       (level),
      .i_rd_data     (rd_data),
      .o_rd_en       (rd_en),
      .o_tx_valid    (o_tx_valid),
      .o_tx_data     (o_tx_data),
      .o_tx_last     (o_tx_last),
      .i_tx_ready    (i_tx_ready),
      .o_word_sent   (word_sent)
   );

   // 8 bytes per data word taken downstream
   always_ff @(posedge clock)
   begin
      if (reset)
         status_q <= '0;
      else if (word_sent)
         status_q <= status_q + 32'd8;
   end

   assign o_status = status_q;

endmodule
